// ==== rtl/fetch_defs.svh ====
`ifndef FETCH_DEFS_SVH
`define FETCH_DEFS_SVH

// ==============================
// Fetch stage widths and sizes
// ==============================

// Address and branch number widths
`define FETCH_PC_W 32
`define FETCH_BNO_W 5

// Every instruction is one fixed-size word, four to a line
`define FETCH_SLOTS 4
`define FETCH_INSN_W 32
`define FETCH_LINE_W (`FETCH_INSN_W * `FETCH_SLOTS)
`define FETCH_INJ_W (`FETCH_INSN_W * `FETCH_SLOTS / 2)

// Byte step from slot to slot and from line to line
`define FETCH_INSN_BYTES 4
`define FETCH_LINE_BYTES (`FETCH_INSN_BYTES * `FETCH_SLOTS)

// Where fetch starts, and how many bundles are NOP-filled while the pipe warms up
`define FETCH_RST_PC 32'h0000_0100
`define FETCH_RST_FILL 4

`endif

// ==== rtl/fetch_pkg.sv ====
`include "fetch_defs.svh"

package fetch_pkg;

	// ==============================
	// Scalar types
	// ==============================

	// One fetch address, and the branch number that tags its path
	typedef logic [`FETCH_PC_W-1:0] pc_t;
	typedef logic [`FETCH_BNO_W-1:0] bno_t;

	// One fixed-width instruction word
	typedef logic [`FETCH_INSN_W-1:0] insn_t;

	// PC together with the branch number it was fetched under
	typedef struct packed {
		pc_t pc;
		bno_t bno;
	} pc_addr_t;

	// ==============================
	// Line and bundle types
	// ==============================

	// Slot 0 sits in the low word of the line
	typedef insn_t [`FETCH_SLOTS-1:0] fetch_line_t;

	// An injected line fills only the lower half of the slots
	typedef insn_t [`FETCH_SLOTS/2-1:0] inject_line_t;

	// One PC per slot
	typedef pc_t [`FETCH_SLOTS-1:0] slot_pcs_t;

	// Everything the stage hands downstream in one transfer
	typedef struct packed {
		pc_addr_t base;
		slot_pcs_t slot_pc;
		fetch_line_t line;
		logic nop_fill;
		logic injected;
	} fetch_bundle_t;

	// Word placed in every slot that carries no real instruction
	localparam insn_t OP_NOP = 32'h0000_0013;

endpackage

// ==== rtl/fetch_if.sv ====
`timescale 1ns/1ns

// ==============================
// PC path
// ==============================

// Carries the current fetch PC from the sequencer to the stage register,
// and the advance request back the other way
interface fetch_pc_if;
	import fetch_pkg::*;

	// PC and branch number presented to the instruction source this cycle
	pc_addr_t cur;
	// High when the line at cur was consumed by the stage this cycle
	logic advance;
	// Redirect request from outside the fetch stage
	logic redirect_valid;
	pc_t redirect_pc;

	// The sequencer owns cur and follows advance and redirect
	modport seq (
		output cur,
		input advance,
		input redirect_valid,
		input redirect_pc
	);

	// The stage reads cur and decides when it has been used
	modport stage (
		input cur,
		output advance
	);
endinterface

// ==============================
// Line path
// ==============================

// Carries the filtered line and its flags from the filter to the stage register
interface fetch_line_if;
	import fetch_pkg::*;

	// Selected line for the current PC
	fetch_line_t line;
	// Line is all NOPs, either from reset fill or a kill
	logic nop_fill;
	// Line came from the inject port rather than the source
	logic injected;
	// High when the stage captured a bundle this cycle
	logic take;

	modport filter (
		output line,
		output nop_fill,
		output injected,
		input take
	);

	modport stage (
		input line,
		input nop_fill,
		input injected,
		output take
	);
endinterface

// ==== rtl/fetch_pc_seq.sv ====
`timescale 1ns/1ns
`include "fetch_defs.svh"

// Fetch PC sequencer.
// Holds the PC being fetched and the branch number of the current path.
// A redirect always wins and starts a new path, so every redirect gets
// a fresh branch number that later stages can use to stomp old work.
module fetch_pc_seq (
	input logic clk,
	input logic rst,
	fetch_pc_if.seq pc_if
);
	import fetch_pkg::*;

	// ==============================
	// State
	// ==============================

	// Registered PC and branch number
	pc_addr_t cur_q;

	// Next value of the PC on a sequential step
	pc_t seq_pc;

	// Line step is a whole line of bytes
	assign seq_pc = cur_q.pc + `FETCH_PC_W'(`FETCH_LINE_BYTES);

	// ==============================
	// Update
	// ==============================

	always_ff @(posedge clk) begin
		if (rst) begin
			// Fetch starts at the reset vector on path number one
			cur_q.pc <= `FETCH_RST_PC;
			cur_q.bno <= `FETCH_BNO_W'(1);
		end else if (pc_if.redirect_valid) begin
			// Redirect is taken even while the stage is stalled
			cur_q.pc <= pc_if.redirect_pc;
			// Branch number wraps naturally at its width
			cur_q.bno <= cur_q.bno + `FETCH_BNO_W'(1);
		end else if (pc_if.advance) begin
			// The stage used this line, so move on to the next one
			cur_q.pc <= seq_pc;
		end
	end

	// Without advance or redirect the PC simply holds.
	// That covers both back-pressure and injected bundles, which replay
	// the same PC on the following cycle

	// The current PC goes straight out to the source and the stage
	assign pc_if.cur = cur_q;

endmodule

// ==== rtl/fetch_line_filter.sv ====
`timescale 1ns/1ns
`include "fetch_defs.svh"

// Line filter.
// Picks the line that enters the next bundle: a NOP fill while the pipe
// warms up after reset, an injected half line, a NOP fill on a kill, or
// else the line returned by the instruction source.
module fetch_line_filter (
	input logic clk,
	input logic rst,
	input logic [`FETCH_BNO_W-1:0] cur_bno_i,
	input fetch_pkg::fetch_line_t line_i,
	input logic hit_i,
	input logic flush_i,
	input logic nmi_i,
	input logic stomp_valid_i,
	input logic [`FETCH_BNO_W-1:0] stomp_bno_i,
	input logic inject_valid_i,
	input fetch_pkg::inject_line_t inject_line_i,
	fetch_line_if.filter line_if
);
	import fetch_pkg::*;

	// Counter just wide enough to reach the fill length
	localparam int FILL_W = $clog2(`FETCH_RST_FILL + 1);

	// A line of nothing but NOPs
	localparam fetch_line_t NOP_LINE = {`FETCH_SLOTS{OP_NOP}};

	logic [FILL_W-1:0] fill_cnt;
	logic in_fill;
	logic kill;
	fetch_line_t inj_line;

	// ==============================
	// Post-reset fill counter
	// ==============================

	assign in_fill = fill_cnt < FILL_W'(`FETCH_RST_FILL);

	// Counts captured bundles and stops once the fill is done
	always_ff @(posedge clk) begin
		if (rst)
			fill_cnt <= '0;
		else if (line_if.take && in_fill)
			fill_cnt <= fill_cnt + FILL_W'(1);
	end

	// ==============================
	// Selection
	// ==============================

	// A stomp only kills lines fetched on some other path
	assign kill = !hit_i || flush_i || nmi_i ||
		(stomp_valid_i && (cur_bno_i != stomp_bno_i));

	// Injected words go in the low slots, NOPs above them
	always_comb begin
		inj_line = NOP_LINE;
		for (int k = 0; k < `FETCH_SLOTS/2; k++)
			inj_line[k] = inject_line_i[k];
	end

	// Priority is fill, then inject, then kill, then the fetched line
	always_comb begin
		line_if.line = line_i;
		line_if.nop_fill = 1'b0;
		line_if.injected = 1'b0;
		if (in_fill) begin
			line_if.line = NOP_LINE;
			line_if.nop_fill = 1'b1;
		end else if (inject_valid_i) begin
			line_if.line = inj_line;
			line_if.injected = 1'b1;
		end else if (kill) begin
			line_if.line = NOP_LINE;
			line_if.nop_fill = 1'b1;
		end
	end

endmodule

// ==== rtl/fetch_stage_reg.sv ====
`timescale 1ns/1ns
`include "fetch_defs.svh"

// Fetch stage register.
// Joins the current PC and the filtered line into one bundle, works out
// the PC of every slot, and holds the bundle until downstream accepts it.
module fetch_stage_reg (
	input logic clk,
	input logic rst,
	fetch_pc_if.stage pc_if,
	fetch_line_if.stage line_if,
	input logic inject_valid_i,
	output fetch_pkg::fetch_bundle_t bundle_o,
	output logic valid_o,
	input logic ready_i
);
	import fetch_pkg::*;

	// Stage loads a new bundle this cycle
	logic take;

	// Slot PCs for the line at the current PC
	slot_pcs_t slot_pc;

	// Held bundle and its valid flag
	fetch_bundle_t bundle_q;
	logic valid_q;

	// ==============================
	// Handshake
	// ==============================

	// Capture when empty or when the held bundle leaves this cycle
	assign take = !valid_q || ready_i;

	// The filter counts fill bundles on take
	assign line_if.take = take;

	// An injected bundle leaves the PC where it is, so the
	// fetched line at that PC comes through on a later cycle
	assign pc_if.advance = take && !inject_valid_i;

	// ==============================
	// Slot PC expansion
	// ==============================

	// Slot k sits k instruction words above the base PC
	always_comb begin
		for (int k = 0; k < `FETCH_SLOTS; k++)
			slot_pc[k] = pc_if.cur.pc + `FETCH_PC_W'(k * `FETCH_INSN_BYTES);
	end

	// ==============================
	// Registers
	// ==============================

	// Once something is captured the source keeps the stage full,
	// so valid only drops through reset
	always_ff @(posedge clk) begin
		if (rst)
			valid_q <= 1'b0;
		else if (take)
			valid_q <= 1'b1;
	end

	// Payload loads on take and otherwise holds under back-pressure
	always_ff @(posedge clk) begin
		if (take) begin
			bundle_q.base <= pc_if.cur;
			bundle_q.slot_pc <= slot_pc;
			bundle_q.line <= line_if.line;
			bundle_q.nop_fill <= line_if.nop_fill;
			bundle_q.injected <= line_if.injected;
		end
	end

	assign bundle_o = bundle_q;
	assign valid_o = valid_q;

endmodule

// ==== rtl/fetch_unit.sv ====
`timescale 1ns/1ns
`include "fetch_defs.svh"

// Fetch unit top level.
// The PC sequencer and the line filter both work on the current PC in
// the same cycle, and the stage register combines what they produce into
// one bundle that goes out over valid/ready.
module fetch_unit (
	input logic clk,
	input logic rst,

	// Redirect from later in the pipeline
	input logic redirect_valid_i,
	input logic [`FETCH_PC_W-1:0] redirect_pc_i,

	// Instruction source, answered within the same cycle
	output logic [`FETCH_PC_W-1:0] fetch_pc_o,
	input fetch_pkg::fetch_line_t line_i,
	input logic hit_i,

	// Injected half line
	input logic inject_valid_i,
	input fetch_pkg::inject_line_t inject_line_i,

	// Kill sources
	input logic flush_i,
	input logic nmi_i,
	input logic stomp_valid_i,
	input logic [`FETCH_BNO_W-1:0] stomp_bno_i,

	// Bundle output
	output logic out_valid_o,
	input logic out_ready_i,
	output logic [`FETCH_PC_W-1:0] out_pc_o,
	output logic [`FETCH_BNO_W-1:0] out_bno_o,
	output fetch_pkg::slot_pcs_t out_slot_pc_o,
	output fetch_pkg::fetch_line_t out_line_o,
	output logic out_nop_fill_o,
	output logic out_injected_o
);
	import fetch_pkg::*;

	// ==============================
	// Internal paths
	// ==============================

	fetch_pc_if pc_bus ();
	fetch_line_if line_bus ();

	// Bundle as it leaves the stage register
	fetch_bundle_t bundle;

	// Redirect enters through the sequencer side of the PC path
	assign pc_bus.redirect_valid = redirect_valid_i;
	assign pc_bus.redirect_pc = redirect_pc_i;

	// The source sees the live PC
	assign fetch_pc_o = pc_bus.cur.pc;

	// ==============================
	// Instances
	// ==============================

	fetch_pc_seq u_pc_seq (
		.clk(clk),
		.rst(rst),
		.pc_if(pc_bus.seq)
	);

	// The filter needs the current branch number for the stomp test
	fetch_line_filter u_line_filter (
		.clk(clk),
		.rst(rst),
		.cur_bno_i(pc_bus.cur.bno),
		.line_i(line_i),
		.hit_i(hit_i),
		.flush_i(flush_i),
		.nmi_i(nmi_i),
		.stomp_valid_i(stomp_valid_i),
		.stomp_bno_i(stomp_bno_i),
		.inject_valid_i(inject_valid_i),
		.inject_line_i(inject_line_i),
		.line_if(line_bus.filter)
	);

	fetch_stage_reg u_stage_reg (
		.clk(clk),
		.rst(rst),
		.pc_if(pc_bus.stage),
		.line_if(line_bus.stage),
		.inject_valid_i(inject_valid_i),
		.bundle_o(bundle),
		.valid_o(out_valid_o),
		.ready_i(out_ready_i)
	);

	// Bundle fields broken out onto plain ports
	assign out_pc_o = bundle.base.pc;
	assign out_bno_o = bundle.base.bno;
	assign out_slot_pc_o = bundle.slot_pc;
	assign out_line_o = bundle.line;
	assign out_nop_fill_o = bundle.nop_fill;
	assign out_injected_o = bundle.injected;

endmodule

// ==== sim/fetch_unit_properties.sv ====
`timescale 1ns/1ns
`include "fetch_defs.svh"

// Concurrent checks on the output side of the fetch unit.
// Port names match the top level so the module binds by name
module fetch_unit_properties (
	input logic clk,
	input logic rst,
	input logic out_valid_o,
	input logic out_ready_i,
	input logic [`FETCH_PC_W-1:0] out_pc_o,
	input logic [`FETCH_BNO_W-1:0] out_bno_o,
	input fetch_pkg::slot_pcs_t out_slot_pc_o,
	input fetch_pkg::fetch_line_t out_line_o,
	input logic out_nop_fill_o,
	input logic out_injected_o
);

	// Number of assertion failures seen so far
	int fail_count = 0;

	// Synchronous reset empties the stage at the edge that sees it
	reset_clears_valid: assert property (@(posedge clk) rst |=> !out_valid_o)
		else begin
			$error("out_valid_o still high after a reset edge");
			fail_count++;
		end

	// A stalled bundle keeps every field until downstream takes it
	held_bundle_stable: assert property (@(posedge clk) disable iff (rst)
		out_valid_o && !out_ready_i |=> out_valid_o && $stable(out_pc_o) &&
		$stable(out_bno_o) && $stable(out_slot_pc_o) && $stable(out_line_o) &&
		$stable(out_nop_fill_o) && $stable(out_injected_o))
		else begin
			$error("bundle changed or dropped while out_ready_i was low");
			fail_count++;
		end

	// A line is either filled or injected, never both
	flags_exclusive: assert property (@(posedge clk) disable iff (rst)
		out_valid_o |-> !(out_nop_fill_o && out_injected_o))
		else begin
			$error("out_nop_fill_o and out_injected_o both set");
			fail_count++;
		end

endmodule

// ==== sim/fetch_unit_tb.sv ====
`timescale 1ns/1ns
`include "fetch_defs.svh"

module fetch_unit_tb;
	import fetch_pkg::*;

	// ==============================
	// Run length and signals
	// ==============================

	localparam int N_XFERS = 2000;
	// Ready is high about 70% of the time, so 2000 transfers take near 2900 cycles
	localparam int MAX_CYCLES = 3000 + 1000;

	logic clk;
	logic rst;
	logic redirect_valid_i;
	logic [`FETCH_PC_W-1:0] redirect_pc_i;
	logic [`FETCH_PC_W-1:0] fetch_pc_o;
	fetch_line_t line_i;
	logic hit_i;
	logic inject_valid_i;
	inject_line_t inject_line_i;
	logic flush_i;
	logic nmi_i;
	logic stomp_valid_i;
	logic [`FETCH_BNO_W-1:0] stomp_bno_i;
	logic out_valid_o;
	logic out_ready_i;
	logic [`FETCH_PC_W-1:0] out_pc_o;
	logic [`FETCH_BNO_W-1:0] out_bno_o;
	slot_pcs_t out_slot_pc_o;
	fetch_line_t out_line_o;
	logic out_nop_fill_o;
	logic out_injected_o;

	// Model state holds the PC and bno for the next edge, the fill count and the occupancy
	pc_addr_t m_cur;
	int m_fill;
	logic m_valid;
	fetch_bundle_t exp_q[$];
	int cycles = 0;
	int xfers = 0;

	fetch_unit u_fetch_unit (.*);

	bind fetch_unit fetch_unit_properties u_props (.*);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// Every failure ends up here
	task automatic stop_on_error(string why);
		$display("%s", why);
		$display("test failed");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_fetch_pc(string name, pc_t got, pc_t exp);
		if (got !== exp)
			stop_on_error($sformatf("Mismatch %s: got %h expected %h", name, got, exp));
	endtask

	task automatic check_pc(string name, pc_addr_t got, pc_addr_t exp);
		if (got !== exp)
			stop_on_error($sformatf("Mismatch %s: got %h expected %h", name, got, exp));
	endtask

	task automatic check_slots(string name, slot_pcs_t got, slot_pcs_t exp);
		if (got !== exp)
			stop_on_error($sformatf("Mismatch %s: got %h expected %h", name, got, exp));
	endtask

	task automatic check_line(string name, fetch_line_t got, fetch_line_t exp);
		if (got !== exp)
			stop_on_error($sformatf("Mismatch %s: got %h expected %h", name, got, exp));
	endtask

	task automatic check_flags(string name, logic got, logic exp);
		if (got !== exp)
			stop_on_error($sformatf("Mismatch %s: got %h expected %h", name, got, exp));
	endtask

	// Stand-in for the instruction source that returns a fixed scramble of the PC
	function automatic fetch_line_t line_hash(pc_t pc);
		fetch_line_t l;
		for (int k = 0; k < `FETCH_SLOTS; k++)
			l[k] = (pc ^ (32'h9e37_79b9 * (k + 1))) + {pc[7:0], 24'h5a_0000};
		return l;
	endfunction

	// Builds a line of NOPs with the injected half in the low slots when asked
	function automatic fetch_line_t padded_line(inject_line_t half, logic use_half);
		fetch_line_t l;
		for (int k = 0; k < `FETCH_SLOTS; k++) begin
			if (use_half && k < `FETCH_SLOTS / 2)
				l[k] = half[k];
			else
				l[k] = OP_NOP;
		end
		return l;
	endfunction

	// Rare events fire a few percent of the time and ready is mostly high
	task automatic drive_random();
		hit_i = ($urandom % 100) >= 8;
		out_ready_i = ($urandom % 100) < 70;
		redirect_valid_i = ($urandom % 100) < 4;
		redirect_pc_i = $urandom & 32'hffff_fff0;
		inject_valid_i = ($urandom % 100) < 5;
		inject_line_i = {$urandom, $urandom};
		flush_i = ($urandom % 100) < 3;
		nmi_i = ($urandom % 100) < 2;
		stomp_valid_i = ($urandom % 100) < 5;
		// Half of the stomps match the live path and must not kill it
		stomp_bno_i = ($urandom % 2) ? m_cur.bno : `FETCH_BNO_W'($urandom);
		line_i = line_hash(fetch_pc_o);
	endtask

	always @(posedge clk) begin
		cycles++;
		if (cycles > MAX_CYCLES)
			stop_on_error($sformatf("Timeout: only %0d of %0d bundles came out in %0d cycles",
				xfers, N_XFERS, cycles));
	end

	// Bound assertions count their failures and the first one ends the run
	always @(negedge clk) begin
		if (u_fetch_unit.u_props.fail_count != 0)
			stop_on_error("A bound assertion on the fetch unit outputs failed");
	end

	initial begin
		fetch_bundle_t b;
		logic take;
		logic kill;
		void'($urandom(33));
		rst = 1'b1;
		{redirect_valid_i, inject_valid_i, flush_i, nmi_i, stomp_valid_i} = '0;
		redirect_pc_i = '0;
		inject_line_i = '0;
		stomp_bno_i = '0;
		line_i = '0;
		hit_i = 1'b1;
		out_ready_i = 1'b1;
		repeat (2) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		m_cur.pc = `FETCH_RST_PC;
		m_cur.bno = `FETCH_BNO_W'(1);
		m_fill = 0;
		m_valid = 1'b0;
		// Outputs are registered, so at the falling edge they show the held bundle
		while (xfers < N_XFERS) begin
			// The source must see the PC the model expects for the coming edge
			check_fetch_pc("fetch_pc_o", fetch_pc_o, m_cur.pc);
			drive_random();
			check_flags("out_valid_o", out_valid_o, m_valid);
			if (m_valid) begin
				b = exp_q[0];
				check_pc("out_pc_o/out_bno_o", {out_pc_o, out_bno_o}, b.base);
				check_slots("out_slot_pc_o", out_slot_pc_o, b.slot_pc);
				check_line("out_line_o", out_line_o, b.line);
				check_flags("out_nop_fill_o", out_nop_fill_o, b.nop_fill);
				check_flags("out_injected_o", out_injected_o, b.injected);
			end
			if (m_valid && out_ready_i) begin
				void'(exp_q.pop_front());
				xfers++;
			end
			// The stage loads whenever it is empty or its bundle leaves
			take = !m_valid || out_ready_i;
			kill = !hit_i || flush_i || nmi_i || (stomp_valid_i && stomp_bno_i != m_cur.bno);
			if (take) begin
				b.base = m_cur;
				for (int k = 0; k < `FETCH_SLOTS; k++)
					b.slot_pc[k] = m_cur.pc + k * `FETCH_INSN_BYTES;
				b.nop_fill = (m_fill < `FETCH_RST_FILL) || (!inject_valid_i && kill);
				b.injected = (m_fill >= `FETCH_RST_FILL) && inject_valid_i;
				if (b.nop_fill || b.injected)
					b.line = padded_line(inject_line_i, b.injected);
				else
					b.line = line_hash(m_cur.pc);
				exp_q.push_back(b);
				if (m_fill < `FETCH_RST_FILL)
					m_fill++;
				m_valid = 1'b1;
			end
			// Redirect wins and opens a new path, an injected bundle keeps the PC
			if (redirect_valid_i) begin
				m_cur.pc = redirect_pc_i;
				m_cur.bno = m_cur.bno + 1'b1;
			end else if (take && !inject_valid_i) begin
				m_cur.pc = m_cur.pc + `FETCH_INSN_BYTES * `FETCH_SLOTS;
			end
			@(negedge clk);
		end
		if (u_fetch_unit.u_props.fail_count != 0) begin
			stop_on_error("A bound assertion on the fetch unit outputs failed");
		end else begin
			$display("test passed");
			$finish;
		end
	end

endmodule

// ==== fetch_unit.f ====
+incdir+rtl
rtl/fetch_pkg.sv
rtl/fetch_if.sv
rtl/fetch_pc_seq.sv
rtl/fetch_line_filter.sv
rtl/fetch_stage_reg.sv
rtl/fetch_unit.sv
sim/fetch_unit_properties.sv
sim/fetch_unit_tb.sv
